// File: common/conv_pkg.sv
package conv_pkg;

  localparam int LWIDTH = 4;   // Image, filter and feature sizes.
  localparam int DWIDTH = 8;   // Unsigned pixel.
  localparam int WWIDTH = 8;   // Signed weight.
  localparam int FWIDTH = 24;  // Signed feature value.

  // Window control to feature-memory read, set by the two MAC stages.
  localparam int D_CONV  = 2;
  localparam int D_ACCUM = 1;  // Read-modify-write in the feature memory.

  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_t;

  typedef enum logic [1:0] {
    CORE_WAIT    = 2'd0,
    CORE_NETWORK = 2'd1,
    CORE_INPUT   = 2'd2,
    CORE_OUTPUT  = 2'd3
  } core_state_e;

  typedef logic        [DWIDTH-1:0] pixel_t;
  typedef logic signed [WWIDTH-1:0] weight_t;
  typedef logic signed [FWIDTH-1:0] feat_t;

endpackage

// File: hw/ctrl_conv.sv
`timescale 1ns/10ps

module ctrl_conv #(
  parameter int  IMG_MAX = 8,
  parameter int  FIL_MAX = 3,
  localparam int AWIDTH  = $clog2(IMG_MAX * IMG_MAX)
) (
  input  logic                        clk,
  input  logic                        xrst,
  input  conv_pkg::ctrl_t             in_ctrl,
  input  conv_pkg::core_state_e       core_state,
  input  logic [conv_pkg::LWIDTH-1:0] img_size_in,
  input  logic [conv_pkg::LWIDTH-1:0] fil_size_in,
  input  logic                        first_input,
  input  logic                        last_input,
  output conv_pkg::ctrl_t             conv_ctrl,
  output logic [conv_pkg::LWIDTH-1:0] win_x,
  output logic [conv_pkg::LWIDTH-1:0] win_y,
  output logic                        img_we,
  output logic [AWIDTH-1:0]           img_addr,
  output logic                        mem_feat_we,
  output logic                        mem_feat_rst,
  output logic [AWIDTH-1:0]           mem_feat_addr,
  output logic [AWIDTH-1:0]           mem_feat_addr_d1,
  output logic                        conv_oe,
  output conv_pkg::ctrl_t             out_ctrl,
  output logic [conv_pkg::LWIDTH-1:0] fea_size
);

  localparam int D_CONV = conv_pkg::D_CONV;
  localparam int D_OUT  = conv_pkg::D_CONV + conv_pkg::D_ACCUM;

  typedef enum logic {
    S_WAIT,
    S_ACTIVE
  } state_e;

  state_e                      r_state;
  conv_pkg::core_state_e       r_core_state;
  logic                        r_wait_back;
  logic                        r_first_input;
  logic                        r_last_input;
  logic [conv_pkg::LWIDTH-1:0] r_img_size;
  logic [conv_pkg::LWIDTH-1:0] r_fea_size;
  logic [conv_pkg::LWIDTH-1:0] r_conv_x;
  logic [conv_pkg::LWIDTH-1:0] r_conv_y;
  logic [conv_pkg::LWIDTH-1:0] r_win_x;
  logic [conv_pkg::LWIDTH-1:0] r_win_y;
  logic                        r_img_we;
  logic [AWIDTH-1:0]           r_img_addr;
  logic                        w_in_step;
  logic                        w_out_step;
  logic                        w_in_last;
  logic                        w_out_last;
  conv_pkg::ctrl_t             r_conv_ctrl;
  conv_pkg::ctrl_t             r_out_ctrl [D_OUT];
  logic                        r_feat_we [D_CONV];
  logic                        r_feat_rst [D_CONV];
  logic [AWIDTH-1:0]           r_feat_cnt;  // Aligned with conv_ctrl.
  logic [AWIDTH-1:0]           r_feat_addr [D_CONV+1];

  assign w_in_step  = r_state == S_ACTIVE && r_core_state == conv_pkg::CORE_INPUT
                      && in_ctrl.valid;
  assign w_out_step = r_state == S_ACTIVE && r_core_state == conv_pkg::CORE_OUTPUT
                      && !r_wait_back;
  assign w_in_last  = r_conv_x == r_img_size - 1'b1 && r_conv_y == r_img_size - 1'b1;
  assign w_out_last = r_conv_x == r_fea_size - 1'b1 && r_conv_y == r_fea_size - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state <= S_WAIT;
    end else if (r_state == S_WAIT && in_ctrl.start) begin
      r_state <= S_ACTIVE;
    end else if (r_state == S_ACTIVE && out_ctrl.stop) begin
      r_state <= S_WAIT;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_core_state  <= conv_pkg::CORE_WAIT;
      r_img_size    <= '0;
      r_fea_size    <= '0;
      r_first_input <= 1'b0;
      r_last_input  <= 1'b0;
    end else begin
      r_core_state <= core_state;
      if (r_state == S_WAIT && in_ctrl.start) begin
        r_img_size    <= img_size_in;
        r_fea_size    <= img_size_in - fil_size_in + 1'b1;  // Valid windows only.
        r_first_input <= first_input;
        r_last_input  <= last_input;
      end
    end
  end

  // Raster position: pixels while loading, feature positions while sweeping.
  always_ff @(posedge clk) begin
    if (!xrst || r_state == S_WAIT) begin
      r_conv_x <= '0;
      r_conv_y <= '0;
    end else if (w_in_step) begin
      if (r_conv_x == r_img_size - 1'b1) begin
        r_conv_x <= '0;
        r_conv_y <= w_in_last ? '0 : r_conv_y + 1'b1;
      end else begin
        r_conv_x <= r_conv_x + 1'b1;
      end
    end else if (w_out_step) begin
      if (r_conv_x == r_fea_size - 1'b1) begin
        r_conv_x <= '0;
        r_conv_y <= w_out_last ? '0 : r_conv_y + 1'b1;
      end else begin
        r_conv_x <= r_conv_x + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_conv_ctrl <= '0;
      r_img_we    <= 1'b0;
      r_wait_back <= 1'b0;
    end else begin
      r_conv_ctrl.start <= w_in_step && r_last_input && w_in_last;
      r_conv_ctrl.valid <= w_out_step;
      r_conv_ctrl.stop  <= w_out_step && w_out_last;
      r_img_we          <= w_in_step;
      if (in_ctrl.start) begin
        r_wait_back <= 1'b0;
      end else if (w_out_step && w_out_last) begin
        r_wait_back <= 1'b1;  // Hold off until the next pass.
      end
    end
  end

  always_ff @(posedge clk) begin
    r_win_x    <= r_conv_x;
    r_win_y    <= r_conv_y;
    r_img_addr <= AWIDTH'(r_conv_y * IMG_MAX + r_conv_x);
    r_feat_addr[0] <= r_feat_cnt;
    for (int i = 1; i <= D_CONV; i++) begin
      r_feat_addr[i] <= r_feat_addr[i-1];
    end
  end

  // Feature-memory control and the output control chain.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_feat_cnt <= '0;
      for (int i = 0; i < D_CONV; i++) begin
        r_feat_we[i]  <= 1'b0;
        r_feat_rst[i] <= 1'b0;
      end
      for (int i = 0; i < D_OUT; i++) begin
        r_out_ctrl[i] <= '0;
      end
    end else begin
      if (r_state == S_WAIT || r_conv_ctrl.stop) begin
        r_feat_cnt <= '0;
      end else if (r_conv_ctrl.valid) begin
        r_feat_cnt <= r_feat_cnt + 1'b1;
      end
      r_feat_we[0]  <= r_conv_ctrl.valid;
      r_feat_rst[0] <= r_conv_ctrl.valid && r_first_input;
      for (int i = 1; i < D_CONV; i++) begin
        r_feat_we[i]  <= r_feat_we[i-1];
        r_feat_rst[i] <= r_feat_rst[i-1];
      end
      r_out_ctrl[0] <= r_conv_ctrl;  // Accum control runs with conv_ctrl.
      for (int i = 1; i < D_OUT; i++) begin
        r_out_ctrl[i] <= r_out_ctrl[i-1];
      end
    end
  end

  assign conv_ctrl        = r_conv_ctrl;
  assign win_x            = r_win_x;
  assign win_y            = r_win_y;
  assign img_we           = r_img_we;
  assign img_addr         = r_img_addr;
  assign mem_feat_we      = r_feat_we[D_CONV-1];
  assign mem_feat_rst     = r_feat_rst[D_CONV-1];
  assign mem_feat_addr    = r_feat_addr[D_CONV-1];
  assign mem_feat_addr_d1 = r_feat_addr[D_CONV];
  assign conv_oe          = r_out_ctrl[D_OUT-2].valid;
  assign out_ctrl         = r_out_ctrl[D_OUT-1];
  assign fea_size         = r_fea_size;

  a_start_sizes: assert property (@(posedge clk) disable iff (!xrst)
    r_state == S_WAIT && in_ctrl.start |->
      fil_size_in != 0 && fil_size_in <= FIL_MAX
      && fil_size_in <= img_size_in && img_size_in <= IMG_MAX);

  // The counters see the registered phase.
  a_valid_input: assert property (@(posedge clk) disable iff (!xrst)
    in_ctrl.valid |-> r_core_state == conv_pkg::CORE_INPUT);

endmodule

// File: conv/conv_window.sv
`timescale 1ns/10ps

module conv_window #(
  parameter int  IMG_MAX = 8,
  parameter int  FIL_MAX = 3,
  localparam int AWIDTH  = $clog2(IMG_MAX * IMG_MAX),
  localparam int WAWIDTH = $clog2(FIL_MAX * FIL_MAX)
) (
  input  logic                        clk,
  input  logic                        xrst,
  input  logic                        img_we,
  input  logic [AWIDTH-1:0]           img_addr,
  input  conv_pkg::pixel_t            in_data,
  input  logic                        weight_we,
  input  logic [WAWIDTH-1:0]          weight_addr,
  input  conv_pkg::weight_t           weight_data,
  input  conv_pkg::ctrl_t             conv_ctrl,
  input  logic [conv_pkg::LWIDTH-1:0] win_x,
  input  logic [conv_pkg::LWIDTH-1:0] win_y,
  input  logic [conv_pkg::LWIDTH-1:0] fil_size,
  output conv_pkg::feat_t             conv_sum
);

  localparam int NTAP   = FIL_MAX * FIL_MAX;
  localparam int PWIDTH = conv_pkg::DWIDTH + conv_pkg::WWIDTH + 1;

  // Image stored with a stride of IMG_MAX, weights with a stride of FIL_MAX.
  conv_pkg::pixel_t         r_img [IMG_MAX*IMG_MAX];
  conv_pkg::weight_t        r_weight [NTAP];
  conv_pkg::pixel_t         r_pixel;
  conv_pkg::pixel_t         w_tap [NTAP];
  logic signed [PWIDTH-1:0] r_prod [NTAP];
  logic                     r_prod_valid;
  conv_pkg::feat_t          w_sum;
  conv_pkg::feat_t          r_sum;

  always_ff @(posedge clk) begin
    r_pixel <= in_data;  // Lines up with the delayed write address.
    if (img_we) begin
      r_img[img_addr] <= r_pixel;
    end
    if (weight_we) begin
      r_weight[weight_addr] <= weight_data;
    end
  end

  // Taps outside the filter or the buffer read as zero.
  always_comb begin
    for (int ky = 0; ky < FIL_MAX; ky++) begin
      for (int kx = 0; kx < FIL_MAX; kx++) begin
        w_tap[ky*FIL_MAX+kx] = '0;
        if (ky < int'(fil_size) && kx < int'(fil_size)
            && int'(win_y) + ky < IMG_MAX && int'(win_x) + kx < IMG_MAX) begin
          w_tap[ky*FIL_MAX+kx] = r_img[(int'(win_y) + ky) * IMG_MAX + int'(win_x) + kx];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_prod_valid <= 1'b0;
    end else begin
      r_prod_valid <= conv_ctrl.valid;
    end
  end

  // Stage 1.
  always_ff @(posedge clk) begin
    if (conv_ctrl.valid) begin
      for (int k = 0; k < NTAP; k++) begin
        r_prod[k] <= $signed({1'b0, w_tap[k]}) * r_weight[k];
      end
    end
  end

  always_comb begin
    w_sum = '0;
    for (int k = 0; k < NTAP; k++) begin
      w_sum = w_sum + conv_pkg::feat_t'(r_prod[k]);
    end
  end

  // Stage 2.
  always_ff @(posedge clk) begin
    if (r_prod_valid) begin
      r_sum <= w_sum;
    end
  end

  assign conv_sum = r_sum;

  a_window_bound: assert property (@(posedge clk) disable iff (!xrst)
    conv_ctrl.valid |-> int'(win_x) + int'(fil_size) <= IMG_MAX
                        && int'(win_y) + int'(fil_size) <= IMG_MAX);

endmodule

// File: conv/conv_accum.sv
`timescale 1ns/10ps

module conv_accum #(
  parameter int  IMG_MAX = 8,
  localparam int AWIDTH  = $clog2(IMG_MAX * IMG_MAX)
) (
  input  logic              clk,
  input  logic              xrst,
  input  logic              mem_feat_we,
  input  logic              mem_feat_rst,
  input  logic [AWIDTH-1:0] mem_feat_addr,
  input  logic [AWIDTH-1:0] mem_feat_addr_d1,
  input  conv_pkg::feat_t   conv_sum,
  input  logic              conv_oe,
  output conv_pkg::feat_t   out_data
);

  conv_pkg::feat_t mem_feat [IMG_MAX*IMG_MAX];
  conv_pkg::feat_t w_old;
  conv_pkg::feat_t w_new;
  conv_pkg::feat_t r_wdata;
  conv_pkg::feat_t r_out;
  logic            r_we;

  assign w_old = mem_feat[mem_feat_addr];
  // First pass of a layer overwrites.
  assign w_new = mem_feat_rst ? conv_sum : w_old + conv_sum;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_we <= 1'b0;
    end else begin
      r_we <= mem_feat_we;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_feat_we) begin
      r_wdata <= w_new;
    end
    if (r_we) begin
      mem_feat[mem_feat_addr_d1] <= r_wdata;  // Write back one cycle after the read.
    end
  end

  // Output register takes the value being written.
  always_ff @(posedge clk) begin
    if (conv_oe) begin
      r_out <= w_new;
    end
  end

  assign out_data = r_out;

  a_rst_with_we: assert property (@(posedge clk) disable iff (!xrst)
    mem_feat_rst |-> mem_feat_we);

  // A read never meets a pending write to the same entry.
  a_no_rmw_hazard: assert property (@(posedge clk) disable iff (!xrst)
    mem_feat_we && r_we |-> mem_feat_addr != mem_feat_addr_d1);

endmodule

// File: hw/conv_top.sv
`timescale 1ns/10ps

module conv_top #(
  parameter int  IMG_MAX = 8,
  parameter int  FIL_MAX = 3,
  localparam int IMG_AW  = $clog2(IMG_MAX * IMG_MAX),
  localparam int FIL_AW  = $clog2(FIL_MAX * FIL_MAX)
) (
  input  logic                        clk,
  input  logic                        xrst,
  input  conv_pkg::ctrl_t             in_ctrl,
  input  conv_pkg::pixel_t            in_data,
  input  conv_pkg::core_state_e       core_state,
  input  logic [conv_pkg::LWIDTH-1:0] img_size,
  input  logic [conv_pkg::LWIDTH-1:0] fil_size,
  input  logic                        first_input,
  input  logic                        last_input,
  input  logic                        weight_we,
  input  logic [FIL_AW-1:0]           weight_addr,
  input  conv_pkg::weight_t           weight_data,
  output conv_pkg::ctrl_t             out_ctrl,
  output conv_pkg::feat_t             out_data,
  output logic [conv_pkg::LWIDTH-1:0] fea_size
);

  conv_pkg::ctrl_t             conv_ctrl;
  logic [conv_pkg::LWIDTH-1:0] win_x;
  logic [conv_pkg::LWIDTH-1:0] win_y;
  logic                        img_we;
  logic [IMG_AW-1:0]           img_addr;
  logic                        mem_feat_we;
  logic                        mem_feat_rst;
  logic [IMG_AW-1:0]           mem_feat_addr;
  logic [IMG_AW-1:0]           mem_feat_addr_d1;
  logic                        conv_oe;
  conv_pkg::feat_t             conv_sum;

  ctrl_conv #(
    .IMG_MAX (IMG_MAX),
    .FIL_MAX (FIL_MAX)
  ) ctrl0 (
    .clk              (clk),
    .xrst             (xrst),
    .in_ctrl          (in_ctrl),
    .core_state       (core_state),
    .img_size_in      (img_size),
    .fil_size_in      (fil_size),
    .first_input      (first_input),
    .last_input       (last_input),
    .conv_ctrl        (conv_ctrl),
    .win_x            (win_x),
    .win_y            (win_y),
    .img_we           (img_we),
    .img_addr         (img_addr),
    .mem_feat_we      (mem_feat_we),
    .mem_feat_rst     (mem_feat_rst),
    .mem_feat_addr    (mem_feat_addr),
    .mem_feat_addr_d1 (mem_feat_addr_d1),
    .conv_oe          (conv_oe),
    .out_ctrl         (out_ctrl),
    .fea_size         (fea_size)
  );

  conv_window #(
    .IMG_MAX (IMG_MAX),
    .FIL_MAX (FIL_MAX)
  ) window0 (
    .clk         (clk),
    .xrst        (xrst),
    .img_we      (img_we),
    .img_addr    (img_addr),
    .in_data     (in_data),
    .weight_we   (weight_we),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .conv_ctrl   (conv_ctrl),
    .win_x       (win_x),
    .win_y       (win_y),
    .fil_size    (fil_size),
    .conv_sum    (conv_sum)
  );

  conv_accum #(
    .IMG_MAX (IMG_MAX)
  ) accum0 (
    .clk              (clk),
    .xrst             (xrst),
    .mem_feat_we      (mem_feat_we),
    .mem_feat_rst     (mem_feat_rst),
    .mem_feat_addr    (mem_feat_addr),
    .mem_feat_addr_d1 (mem_feat_addr_d1),
    .conv_sum         (conv_sum),
    .conv_oe          (conv_oe),
    .out_data         (out_data)
  );

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period.
  end

  // Reset held for two rising edges, released just after the second.
  initial begin
    xrst = 1'b0;
    repeat (2) @(posedge clk);
    #1 xrst = 1'b1;
  end

endmodule

// File: bench/conv_tb.sv
`timescale 1ns/10ps

module conv_tb;

  localparam int IMG_MAX = 8;
  localparam int FIL_MAX = 3;
  localparam int NTAP    = FIL_MAX * FIL_MAX;
  localparam int FIL_AW  = $clog2(NTAP);
  localparam int NROWS   = 9;

  typedef struct packed {
    logic                        first;
    logic                        last;
    logic [conv_pkg::LWIDTH-1:0] img;
    logic [conv_pkg::LWIDTH-1:0] fil;
  } row_t;

  // First, last, image size, filter size. Rows 1 to 3 accumulate one layer.
  row_t rows [NROWS] = '{
    {1'b1, 1'b1, 4'd5, 4'd3},
    {1'b1, 1'b0, 4'd6, 4'd2},
    {1'b0, 1'b0, 4'd6, 4'd2},
    {1'b0, 1'b1, 4'd6, 4'd2},
    {1'b1, 1'b1, 4'd8, 4'd1},
    {1'b1, 1'b0, 4'd3, 4'd3},
    {1'b0, 1'b1, 4'd3, 4'd3},
    {1'b1, 1'b1, 4'd4, 4'd2},
    {1'b1, 1'b1, 4'd7, 4'd3}
  };

  logic                        clk;
  logic                        xrst;
  conv_pkg::ctrl_t             in_ctrl;
  conv_pkg::pixel_t            in_data;
  conv_pkg::core_state_e       core_state;
  logic [conv_pkg::LWIDTH-1:0] img_size;
  logic [conv_pkg::LWIDTH-1:0] fil_size;
  logic                        first_input;
  logic                        last_input;
  logic                        weight_we;
  logic [FIL_AW-1:0]           weight_addr;
  conv_pkg::weight_t           weight_data;
  conv_pkg::ctrl_t             out_ctrl;
  conv_pkg::feat_t             out_data;
  logic [conv_pkg::LWIDTH-1:0] fea_size;

  int                seed   = 38;
  int                checks = 0;
  int                errors = 0;
  int                valid_cnt;
  int                start_cnt;
  int                exp_cnt;
  logic              stop_seen;
  logic              gap_seen;
  conv_pkg::pixel_t  pix [IMG_MAX*IMG_MAX];
  conv_pkg::weight_t wts [NTAP];
  int                exp_map [IMG_MAX*IMG_MAX];  // Running feature map in raster order.

  clock_gen clock0 (
    .clk  (clk),
    .xrst (xrst)
  );

  conv_top #(
    .IMG_MAX (IMG_MAX),
    .FIL_MAX (FIL_MAX)
  ) dut0 (
    .clk         (clk),
    .xrst        (xrst),
    .in_ctrl     (in_ctrl),
    .in_data     (in_data),
    .core_state  (core_state),
    .img_size    (img_size),
    .fil_size    (fil_size),
    .first_input (first_input),
    .last_input  (last_input),
    .weight_we   (weight_we),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .out_ctrl    (out_ctrl),
    .out_data    (out_data),
    .fea_size    (fea_size)
  );

  task automatic check_feat(input conv_pkg::feat_t got, input conv_pkg::feat_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_ctrl(input conv_pkg::ctrl_t got, input conv_pkg::ctrl_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s is %b, expected %b (start valid stop)", $time, what, got, exp);
    end
  endtask

  task automatic check_size(input logic [conv_pkg::LWIDTH-1:0] got,
                            input logic [conv_pkg::LWIDTH-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_weights();
    for (int k = 0; k < NTAP; k++) begin
      next_cycle();
      wts[k]      = conv_pkg::weight_t'($random(seed));
      weight_we   = 1'b1;
      weight_addr = FIL_AW'(k);
      weight_data = wts[k];
    end
    next_cycle();
    weight_we = 1'b0;
  endtask

  task automatic start_pass(input row_t row);
    valid_cnt     = 0;
    start_cnt     = 0;
    stop_seen     = 1'b0;
    gap_seen      = 1'b0;
    exp_cnt       = (int'(row.img) - int'(row.fil) + 1) * (int'(row.img) - int'(row.fil) + 1);
    img_size      = row.img;
    fil_size      = row.fil;
    first_input   = row.first;
    last_input    = row.last;
    in_ctrl.start = 1'b1;
    next_cycle();
    in_ctrl.start = 1'b0;
    core_state    = conv_pkg::CORE_INPUT;
    next_cycle();  // Sequencer sees the phase one cycle late.
  endtask

  task automatic stream_image(input int n);
    for (int p = 0; p < n * n; p++) begin
      pix[p] = conv_pkg::pixel_t'($random(seed));
    end
    for (int p = 0; p < n * n; p++) begin
      in_ctrl.valid = 1'b1;
      in_data       = pix[p];
      next_cycle();
    end
    in_ctrl.valid = 1'b0;
  endtask

  // The valid-window convolution overwrites the map on a first pass and adds to it otherwise.
  function automatic void update_model(input int n, input int f, input logic first);
    int fea;
    int acc;
    fea = n - f + 1;
    for (int fy = 0; fy < fea; fy++) begin
      for (int fx = 0; fx < fea; fx++) begin
        acc = 0;
        for (int ky = 0; ky < f; ky++) begin
          for (int kx = 0; kx < f; kx++) begin
            acc += int'(pix[(fy + ky) * n + fx + kx]) * int'(wts[ky * FIL_MAX + kx]);
          end
        end
        if (first) begin
          exp_map[fy * fea + fx] = acc;
        end else begin
          exp_map[fy * fea + fx] += acc;
        end
      end
    end
  endfunction

  task automatic sweep_output(input int r);
    int cycles;
    cycles     = 0;
    core_state = conv_pkg::CORE_OUTPUT;
    while (!stop_seen && cycles < exp_cnt + 20) begin
      next_cycle();
      cycles++;
    end
    if (!stop_seen) begin
      errors++;
      $display("Row %0d: no stop arrived within %0d cycles of the output phase", r, cycles);
    end
    repeat (4) next_cycle();  // No valid may follow the stop.
    core_state = conv_pkg::CORE_WAIT;
    next_cycle();
  endtask

  // Output monitor samples away from the rising edge.
  always @(negedge clk) begin
    conv_pkg::ctrl_t exp_c;
    if (xrst) begin
      if (out_ctrl.start) start_cnt++;
      if (out_ctrl.valid || out_ctrl.stop) begin
        exp_c.start = 1'b0;
        exp_c.valid = 1'b1;
        exp_c.stop  = valid_cnt == exp_cnt - 1;
        if (stop_seen) begin
          errors++;
          $display("Output at %0t came after the stop of its pass", $time);
        end else if (valid_cnt < exp_cnt) begin
          check_ctrl(out_ctrl, exp_c, $sformatf("out_ctrl of feature %0d", valid_cnt));
          check_feat(out_data, conv_pkg::feat_t'(exp_map[valid_cnt]),
                     $sformatf("feature %0d", valid_cnt));
        end
        if (out_ctrl.valid) valid_cnt++;
        if (out_ctrl.stop) stop_seen = 1'b1;
      end else if (valid_cnt > 0 && !stop_seen && !gap_seen) begin
        errors++;
        gap_seen = 1'b1;
        $display("Output burst broke off at %0t after %0d of %0d features",
                 $time, valid_cnt, exp_cnt);
      end
    end
  end

  initial begin
    row_t row;
    int   n;
    int   f;
    int   row_err;
    in_ctrl     = '0;
    in_data     = '0;
    core_state  = conv_pkg::CORE_WAIT;
    img_size    = '0;
    fil_size    = '0;
    first_input = 1'b0;
    last_input  = 1'b0;
    weight_we   = 1'b0;
    weight_addr = '0;
    weight_data = '0;
    valid_cnt   = 0;
    start_cnt   = 0;
    exp_cnt     = 0;
    stop_seen   = 1'b0;
    gap_seen    = 1'b0;
    wait (xrst === 1'b1);
    repeat (4) begin
      @(negedge clk);
      check_ctrl(out_ctrl, '0, "out_ctrl after reset");
    end
    for (int r = 0; r < NROWS; r++) begin
      row     = rows[r];
      n       = int'(row.img);
      f       = int'(row.fil);
      row_err = errors;
      load_weights();
      start_pass(row);
      check_size(fea_size, conv_pkg::LWIDTH'(n - f + 1), "fea_size");
      stream_image(n);
      update_model(n, f, row.first);
      sweep_output(r);
      check_count(valid_cnt, exp_cnt, "valid count");
      check_count(start_cnt, row.last ? 1 : 0, "start pulse count");
      $display("Row %0d: img %0d fil %0d first %0d last %0d, %0d outputs, %0d errors",
               r, n, f, row.first, row.last, valid_cnt, errors - row_err);
    end
    $display("Rows %0d, checks %0d, errors %0d", NROWS, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog sized from the rows plus time for reset and the idle check.
  initial begin
    int wd_ns;
    wd_ns = 100;
    for (int r = 0; r < NROWS; r++) begin
      wd_ns += (2 * int'(rows[r].img) * int'(rows[r].img) + 40) * 4;
    end
    #(wd_ns);
    $display("Timeout: the run did not finish within %0d ns", wd_ns);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: src.f
common/conv_pkg.sv
hw/ctrl_conv.sv
conv/conv_window.sv
conv/conv_accum.sv
hw/conv_top.sv
bench/clock_gen.sv
bench/conv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the convolution testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module conv_tb -o conv_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/conv_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
echo "Pass message not found"
exit 1
